/* hw/fft_settings.svh */
`ifndef FFT_SETTINGS_SVH
`define FFT_SETTINGS_SVH

// Component widths along the datapath
`define FFT_IN_W    10
`define FFT_S1_W    11
`define FFT_S2_W    12
`define FFT_COEF_W  11

// Q6.18 product, Q3.12 result
`define FFT_PROD_W  24
`define FFT_OUT_W   15

// Block lengths and pipeline fill
`define FFT_BLOCK1  16
`define FFT_DELAY   16
`define FFT_BLOCK2  8
`define FFT_FILL    19

`define FFT_ROM_DEPTH 16

`endif

/* hw/fft_data_pkg.sv */
`include "fft_settings.svh"

package fft_data_pkg;

  // Signed component types, one per datapath format
  typedef logic signed [`FFT_IN_W-1:0]   in_comp_t;
  typedef logic signed [`FFT_S1_W-1:0]   s1_comp_t;
  typedef logic signed [`FFT_S2_W-1:0]   s2_comp_t;
  typedef logic signed [`FFT_COEF_W-1:0] coef_comp_t;
  typedef logic signed [`FFT_PROD_W-1:0] prod_comp_t;
  typedef logic signed [`FFT_OUT_W-1:0]  out_comp_t;

  // Complex samples, real part in the upper bits
  typedef struct packed {in_comp_t re; in_comp_t im;} cplx_in_t;
  typedef struct packed {s1_comp_t re; s1_comp_t im;} cplx_s1_t;
  typedef struct packed {s2_comp_t re; s2_comp_t im;} cplx_s2_t;
  typedef struct packed {coef_comp_t re; coef_comp_t im;} cplx_coef_t;
  typedef struct packed {out_comp_t re; out_comp_t im;} cplx_out_t;

  // One lane carries an up and a down sample per cycle
  typedef struct packed {cplx_in_t up; cplx_in_t down;} lane_in_t;
  typedef struct packed {cplx_s1_t up; cplx_s1_t down;} lane_s1_t;
  typedef struct packed {cplx_s2_t up; cplx_s2_t down;} lane_s2_t;
  typedef struct packed {cplx_out_t up; cplx_out_t down;} lane_out_t;

endpackage

/* hw/fft_ctrl_pkg.sv */
`include "fft_settings.svh"

package fft_ctrl_pkg;

  // Commutator phases
  typedef enum logic [1:0] {
    FILL,
    PASS,
    SWAP
  } comm_state_t;

  // Wide enough for the fill count as well as the block counts
  typedef logic [4:0] blk_cnt_t;

  typedef logic [$clog2(`FFT_ROM_DEPTH)-1:0] rom_addr_t;

endpackage

/* hw/sat_round.sv */
`timescale 1ns/1ps

module sat_round
  import fft_data_pkg::*;
#(
  parameter int NBI_IN  = 6,
  parameter int NBF_IN  = 18,
  parameter int NBI_OUT = 3,
  parameter int NBF_OUT = 12
) (
  input  prod_comp_t sat_in,
  output out_comp_t  sat_out
);

  localparam int NB_IN  = NBI_IN + NBF_IN;
  localparam int NB_OUT = NBI_OUT + NBF_OUT;
  localparam int DROP   = NBF_IN - NBF_OUT;
  localparam int KEEP   = NB_IN - DROP;

  localparam out_comp_t MAX_VAL = {1'b0, {(NB_OUT-1){1'b1}}};
  localparam out_comp_t MIN_VAL = {1'b1, {(NB_OUT-1){1'b0}}};

  logic [KEEP-1:0] trunc;
  logic            ovf;

  // Low fraction bits are simply dropped
  assign trunc = sat_in[NB_IN-1:DROP];

  // Surplus integer bits must all equal the sign
  assign ovf = !((&trunc[KEEP-1:NB_OUT-1]) || !(|trunc[KEEP-1:NB_OUT-1]));

  assign sat_out = ovf ? (trunc[KEEP-1] ? MIN_VAL : MAX_VAL) : trunc[NB_OUT-1:0];

  // Input beyond the output format lands on the matching limit
  always_comb begin
    if ((sat_in >>> DROP) > MAX_VAL) begin
      a_clamp_high: assert final (sat_out == MAX_VAL)
        else $error("sat_round: input above the Q%0d.%0d range not clamped",
                    NBI_OUT, NBF_OUT);
    end else if ((sat_in >>> DROP) < MIN_VAL) begin
      a_clamp_low: assert final (sat_out == MIN_VAL)
        else $error("sat_round: input below the Q%0d.%0d range not clamped",
                    NBI_OUT, NBF_OUT);
    end
  end

endmodule

/* hw/bf_stage1.sv */
`timescale 1ns/1ps
`include "fft_settings.svh"

module bf_stage1
  import fft_data_pkg::*;
  import fft_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  lane_in_t lane0_in,
  input  lane_in_t lane1_in,
  output lane_s1_t s1_lane0,
  output lane_s1_t s1_lane1
);

  localparam blk_cnt_t BLK_LAST = blk_cnt_t'(`FFT_BLOCK1 - 1);

  blk_cnt_t blk_cnt;
  logic     rot;

  // Sum and difference with one bit of growth, difference optionally times -j
  function automatic lane_s1_t butterfly(input lane_in_t x, input logic rot_j);
    lane_s1_t y;
    cplx_s1_t dif;
    y.up.re = x.up.re + x.down.re;
    y.up.im = x.up.im + x.down.im;
    dif.re  = x.up.re - x.down.re;
    dif.im  = x.up.im - x.down.im;
    if (rot_j) begin
      y.down.re = dif.im;
      y.down.im = -dif.re;
    end else begin
      y.down = dif;
    end
    return y;
  endfunction

  // Rotate flag flips every block
  always_ff @(posedge clk) begin
    if (rst) begin
      blk_cnt <= '0;
      rot     <= 1'b0;
    end else if (blk_cnt == BLK_LAST) begin
      blk_cnt <= '0;
      rot     <= ~rot;
    end else begin
      blk_cnt <= blk_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    s1_lane0 <= butterfly(lane0_in, rot);
    s1_lane1 <= butterfly(lane1_in, rot);
  end

endmodule

/* hw/delay_commutator.sv */
`timescale 1ns/1ps
`include "fft_settings.svh"

module delay_commutator
  import fft_data_pkg::*;
  import fft_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  lane_s1_t s1_lane0,
  input  lane_s1_t s1_lane1,
  output lane_s1_t c_lane0,
  output lane_s1_t c_lane1,
  output logic     run
);

  // run leads valid by the two stage 2 registers
  localparam blk_cnt_t FILL_LAST = blk_cnt_t'(`FFT_FILL - 3);
  localparam blk_cnt_t BLK_LAST  = blk_cnt_t'(`FFT_DELAY - 1);

  cplx_s1_t    dl0 [`FFT_DELAY];
  cplx_s1_t    dl1 [`FFT_DELAY];
  comm_state_t state;
  blk_cnt_t    cnt;
  lane_s1_t    mux0;
  lane_s1_t    mux1;

  //////////////////////////////////////////////////
  // Delay lines on the down samples
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    dl0[0] <= s1_lane0.down;
    dl1[0] <= s1_lane1.down;
    for (int i = 1; i < `FFT_DELAY; i++) begin
      dl0[i] <= dl0[i-1];
      dl1[i] <= dl1[i-1];
    end
  end

  //////////////////////////////////////////////////
  // Phase FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FILL;
      cnt   <= '0;
    end else if (state == FILL) begin
      if (cnt == FILL_LAST) begin
        state <= PASS;
        cnt   <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end else if (cnt == BLK_LAST) begin
      state <= (state == PASS) ? SWAP : PASS;
      cnt   <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign run = (state != FILL);

  // In SWAP lane 0 down trades places with lane 1 up
  always_comb begin
    mux0.up   = s1_lane0.up;
    mux0.down = dl0[`FFT_DELAY-1];
    mux1.up   = s1_lane1.up;
    mux1.down = dl1[`FFT_DELAY-1];
    if (state == SWAP) begin
      mux0.down = s1_lane1.up;
      mux1.up   = dl0[`FFT_DELAY-1];
    end
  end

  always_ff @(posedge clk) begin
    c_lane0 <= mux0;
    c_lane1 <= mux1;
  end

  a_phase_at_wrap: assert property (@(posedge clk) disable iff (rst)
    (state != FILL && cnt != BLK_LAST) |=> $stable(state));

  a_run_holds: assert property (@(posedge clk) $fell(run) |-> $past(rst));

endmodule

/* hw/bf_stage2.sv */
`timescale 1ns/1ps
`include "fft_settings.svh"

module bf_stage2
  import fft_data_pkg::*;
  import fft_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  lane_s1_t  c_lane0,
  input  lane_s1_t  c_lane1,
  input  logic      run,
  output lane_out_t lane0_out,
  output lane_out_t lane1_out,
  output logic      valid
);

  localparam blk_cnt_t  BLK_LAST = blk_cnt_t'(`FFT_BLOCK2 - 1);
  localparam rom_addr_t HALF_ROM = rom_addr_t'(`FFT_ROM_DEPTH / 2);

  blk_cnt_t   blk_cnt;
  logic       rot;
  logic [1:0] run_q;
  rom_addr_t  rom_addr;
  lane_s2_t   bf0;
  lane_s2_t   bf1;
  cplx_coef_t coef_up;
  cplx_coef_t coef_dn;
  prod_comp_t prod_up_re;
  prod_comp_t prod_up_im;
  prod_comp_t prod_dn_re;
  prod_comp_t prod_dn_im;
  out_comp_t  sat_up_re;
  out_comp_t  sat_up_im;
  out_comp_t  sat_dn_re;
  out_comp_t  sat_dn_im;

  function automatic lane_s2_t butterfly(input lane_s1_t x, input logic rot_j);
    lane_s2_t y;
    cplx_s2_t dif;
    y.up.re = x.up.re + x.down.re;
    y.up.im = x.up.im + x.down.im;
    dif.re  = x.up.re - x.down.re;
    dif.im  = x.up.im - x.down.im;
    if (rot_j) begin
      y.down.re = dif.im;
      y.down.im = -dif.re;
    end else begin
      y.down = dif;
    end
    return y;
  endfunction

  // Twiddles W32^k scaled by 1023, k = 0..15
  function automatic cplx_coef_t twiddle(input rom_addr_t a);
    cplx_coef_t w;
    case (a)
      4'd0:    w = '{11'sd1023, 11'sd0};
      4'd1:    w = '{11'sd1003, -11'sd200};
      4'd2:    w = '{11'sd945, -11'sd391};
      4'd3:    w = '{11'sd851, -11'sd568};
      4'd4:    w = '{11'sd723, -11'sd723};
      4'd5:    w = '{11'sd568, -11'sd851};
      4'd6:    w = '{11'sd391, -11'sd945};
      4'd7:    w = '{11'sd200, -11'sd1003};
      4'd8:    w = '{11'sd0, -11'sd1023};
      4'd9:    w = '{-11'sd200, -11'sd1003};
      4'd10:   w = '{-11'sd391, -11'sd945};
      4'd11:   w = '{-11'sd568, -11'sd851};
      4'd12:   w = '{-11'sd723, -11'sd723};
      4'd13:   w = '{-11'sd851, -11'sd568};
      4'd14:   w = '{-11'sd945, -11'sd391};
      default: w = '{-11'sd1003, -11'sd200};
    endcase
    return w;
  endfunction

  //////////////////////////////////////////////////
  // Control, counted from the rise of run
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || !run) begin
      blk_cnt <= '0;
      rot     <= 1'b0;
    end else if (blk_cnt == BLK_LAST) begin
      blk_cnt <= '0;
      rot     <= ~rot;
    end else begin
      blk_cnt <= blk_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q <= '0;
    end else begin
      run_q <= {run_q[0], run};
    end
  end

  // Address follows the butterfly register
  always_ff @(posedge clk) begin
    if (rst || !run_q[0]) begin
      rom_addr <= '0;
    end else begin
      rom_addr <= rom_addr + 1'b1;
    end
  end

  assign valid = run_q[1];

  //////////////////////////////////////////////////
  // Butterflies, then twiddle multiply
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    bf0 <= butterfly(c_lane0, rot);
    bf1 <= butterfly(c_lane1, 1'b0);
  end

  // Down sample uses the twiddle half a table away
  assign coef_up = twiddle(rom_addr);
  assign coef_dn = twiddle(rom_addr + HALF_ROM);

  assign prod_up_re = bf1.up.re * coef_up.re - bf1.up.im * coef_up.im;
  assign prod_up_im = bf1.up.re * coef_up.im + bf1.up.im * coef_up.re;
  assign prod_dn_re = bf1.down.re * coef_dn.re - bf1.down.im * coef_dn.im;
  assign prod_dn_im = bf1.down.re * coef_dn.im + bf1.down.im * coef_dn.re;

  sat_round #(.NBI_IN(6), .NBF_IN(18), .NBI_OUT(3), .NBF_OUT(12)) i_sat_up_re (
    .sat_in  (prod_up_re),
    .sat_out (sat_up_re)
  );

  sat_round #(.NBI_IN(6), .NBF_IN(18), .NBI_OUT(3), .NBF_OUT(12)) i_sat_up_im (
    .sat_in  (prod_up_im),
    .sat_out (sat_up_im)
  );

  sat_round #(.NBI_IN(6), .NBF_IN(18), .NBI_OUT(3), .NBF_OUT(12)) i_sat_dn_re (
    .sat_in  (prod_dn_re),
    .sat_out (sat_dn_re)
  );

  sat_round #(.NBI_IN(6), .NBF_IN(18), .NBI_OUT(3), .NBF_OUT(12)) i_sat_dn_im (
    .sat_in  (prod_dn_im),
    .sat_out (sat_dn_im)
  );

  // Outputs stay at zero until the first valid sample
  always_ff @(posedge clk) begin
    if (rst || !run_q[0]) begin
      lane0_out <= '0;
      lane1_out <= '0;
    end else begin
      lane0_out.up.re   <= {bf0.up.re, 3'b000};
      lane0_out.up.im   <= {bf0.up.im, 3'b000};
      lane0_out.down.re <= {bf0.down.re, 3'b000};
      lane0_out.down.im <= {bf0.down.im, 3'b000};
      lane1_out.up.re   <= sat_up_re;
      lane1_out.up.im   <= sat_up_im;
      lane1_out.down.re <= sat_dn_re;
      lane1_out.down.im <= sat_dn_im;
    end
  end

endmodule

/* hw/fft_front_top.sv */
`timescale 1ns/1ps

module fft_front_top
  import fft_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  lane_in_t  lane0_in,
  input  lane_in_t  lane1_in,
  output lane_out_t lane0_out,
  output lane_out_t lane1_out,
  output logic      valid
);

  // Stage 1 to commutator
  lane_s1_t s1_lane0;
  lane_s1_t s1_lane1;

  // Commutator to stage 2
  lane_s1_t c_lane0;
  lane_s1_t c_lane1;
  logic     run;

  bf_stage1 i_bf_stage1 (
    .clk      (clk),
    .rst      (rst),
    .lane0_in (lane0_in),
    .lane1_in (lane1_in),
    .s1_lane0 (s1_lane0),
    .s1_lane1 (s1_lane1)
  );

  delay_commutator i_delay_commutator (
    .clk      (clk),
    .rst      (rst),
    .s1_lane0 (s1_lane0),
    .s1_lane1 (s1_lane1),
    .c_lane0  (c_lane0),
    .c_lane1  (c_lane1),
    .run      (run)
  );

  bf_stage2 i_bf_stage2 (
    .clk       (clk),
    .rst       (rst),
    .c_lane0   (c_lane0),
    .c_lane1   (c_lane1),
    .run       (run),
    .lane0_out (lane0_out),
    .lane1_out (lane1_out),
    .valid     (valid)
  );

endmodule

/* bench/fft_checker.sv */
`timescale 1ns/1ps
`include "fft_settings.svh"

module fft_checker
  import fft_data_pkg::*;
  import fft_ctrl_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input lane_out_t lane0_out,
  input lane_out_t lane1_out,
  input logic      valid
);

  localparam int NUM_WORDS = 274;
  localparam int EXP_BASE  = 18;
  localparam int REC_WORDS = 8;
  localparam int PER_PHASE = 16;

  logic [15:0] mem [NUM_WORDS];
  logic [14:0] act [REC_WORDS];

  // Reset as seen by the edge just before each falling edge
  bit rst_prev   = 1'b1;
  bit edge_rst;
  bit edge_rst_q = 1'b0;
  bit seen_valid;
  int phase      = -1;
  int cyc;
  int n;
  int lat_err;
  int l0_err;
  int l1_err;
  int reset_err;
  int done_tests;
  int failed_tests;
  int value_errors;
  int late_errors;

  initial $readmemh("bench/fft_input.dat", mem);

  function automatic string field_name(input int f);
    case (f)
      0:       return "lane0_out.up.re";
      1:       return "lane0_out.up.im";
      2:       return "lane0_out.down.re";
      3:       return "lane0_out.down.im";
      4:       return "lane1_out.up.re";
      5:       return "lane1_out.up.im";
      6:       return "lane1_out.down.re";
      default: return "lane1_out.down.im";
    endcase
  endfunction

  task automatic report_test(input string name, input int errs);
    done_tests++;
    if (errs != 0) begin
      failed_tests++;
      $display("Test %s: failed with %0d errors", name, errs);
    end else begin
      $display("Test %s: ok", name);
    end
  endtask

  task automatic start_phase();
    if (phase >= 0 && n < PER_PHASE) begin
      $display("Phase %0d was cut off after %0d of %0d outputs", phase, n, PER_PHASE);
    end
    phase++;
    n          = 0;
    seen_valid = 1'b0;
    lat_err    = 0;
    l0_err     = 0;
    l1_err     = 0;
  endtask

  // Outside valid everything sits at zero
  task automatic check_idle();
    if (valid !== 1'b0) begin
      reset_err++;
      $display("[FAIL] t=%0t valid expected 0 got %b", $time, valid);
    end
    if (lane0_out !== '0 || lane1_out !== '0) begin
      reset_err++;
      $display("[FAIL] t=%0t lane0_out/lane1_out expected 0 got %h %h",
               $time, lane0_out, lane1_out);
    end
  endtask

  task automatic compare_record();
    int idx;
    idx    = EXP_BASE + (phase * PER_PHASE + n) * REC_WORDS;
    act[0] = lane0_out.up.re;
    act[1] = lane0_out.up.im;
    act[2] = lane0_out.down.re;
    act[3] = lane0_out.down.im;
    act[4] = lane1_out.up.re;
    act[5] = lane1_out.up.im;
    act[6] = lane1_out.down.re;
    act[7] = lane1_out.down.im;
    for (int f = 0; f < REC_WORDS; f++) begin
      if (act[f] !== mem[idx+f][14:0]) begin
        value_errors++;
        if (f < 4) l0_err++;
        else l1_err++;
        $display("[FAIL] t=%0t %s expected %h got %h",
                 $time, field_name(f), mem[idx+f][14:0], act[f]);
      end
    end
    n++;
    if (n == PER_PHASE && phase == 0) begin
      report_test("fill latency", lat_err);
      report_test("lane 0 butterflies", l0_err);
      report_test("lane 1 twiddle products", l1_err);
    end else if (n == PER_PHASE) begin
      report_test("fill latency after mid-stream reset", lat_err);
      report_test("lane 0 full scale after restart", l0_err);
      report_test("lane 1 saturation after restart", l1_err);
      report_test("reset values", reset_err);
    end
  endtask

  always @(negedge clk) begin
    edge_rst = rst_prev;
    rst_prev = rst;
    if (edge_rst) begin
      if (!edge_rst_q) start_phase();
      cyc = 0;
      check_idle();
    end else begin
      cyc++;
      if (seen_valid && !valid) begin
        lat_err++;
        // Tests of this phase already reported
        if (n == PER_PHASE) late_errors++;
        $display("valid dropped without a reset at t=%0t", $time);
      end
      if (!valid) begin
        check_idle();
      end else begin
        if (!seen_valid && cyc != `FFT_FILL) begin
          lat_err++;
          $display("valid rose %0d cycles after reset release instead of %0d",
                   cyc, `FFT_FILL);
        end
        seen_valid = 1'b1;
        if (n < PER_PHASE) compare_record();
      end
    end
    edge_rst_q = edge_rst;
  end

endmodule

/* bench/tb_fft_front.sv */
`timescale 1ns/1ps
`include "fft_settings.svh"

module tb_fft_front
  import fft_data_pkg::*;
();

  localparam int NUM_WORDS  = 274;
  localparam int STIM_WORDS = 9;
  localparam int NUM_PHASES = 2;
  localparam int NUM_TESTS  = 7;
  localparam int MARGIN     = 50;

  logic        clk;
  logic        rst;
  lane_in_t    lane0_in;
  lane_in_t    lane1_in;
  lane_out_t   lane0_out;
  lane_out_t   lane1_out;
  logic        valid;
  logic [15:0] mem [NUM_WORDS];
  logic        loaded;
  int          total_cycles;

  fft_front_top i_fft_front_top (
    .clk       (clk),
    .rst       (rst),
    .lane0_in  (lane0_in),
    .lane1_in  (lane1_in),
    .lane0_out (lane0_out),
    .lane1_out (lane1_out),
    .valid     (valid)
  );

  fft_checker i_checker (
    .clk       (clk),
    .rst       (rst),
    .lane0_out (lane0_out),
    .lane1_out (lane1_out),
    .valid     (valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset for 3 cycles with new inputs, then hold them for the record's cycle count
  task automatic run_phase(input int p);
    int base;
    base = p * STIM_WORDS;
    @(posedge clk);
    rst               <= 1'b1;
    lane0_in.up.re    <= mem[base+1][`FFT_IN_W-1:0];
    lane0_in.up.im    <= mem[base+2][`FFT_IN_W-1:0];
    lane0_in.down.re  <= mem[base+3][`FFT_IN_W-1:0];
    lane0_in.down.im  <= mem[base+4][`FFT_IN_W-1:0];
    lane1_in.up.re    <= mem[base+5][`FFT_IN_W-1:0];
    lane1_in.up.im    <= mem[base+6][`FFT_IN_W-1:0];
    lane1_in.down.re  <= mem[base+7][`FFT_IN_W-1:0];
    lane1_in.down.im  <= mem[base+8][`FFT_IN_W-1:0];
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (int'(mem[base])) @(posedge clk);
  endtask

  initial begin
    rst          = 1'b1;
    lane0_in     = '0;
    lane1_in     = '0;
    loaded       = 1'b0;
    total_cycles = 0;
    $readmemh("bench/fft_input.dat", mem);
    for (int p = 0; p < NUM_PHASES; p++) begin
      total_cycles += 4 + int'(mem[p*STIM_WORDS]);
    end
    loaded = 1'b1;
    for (int p = 0; p < NUM_PHASES; p++) begin
      run_phase(p);
    end
    @(posedge clk);
    if (i_checker.done_tests != NUM_TESTS) begin
      $display("Only %0d of %0d tests completed", i_checker.done_tests, NUM_TESTS);
    end
    $display("Summary: %0d tests run, %0d failed, %0d value errors, %0d late errors",
             i_checker.done_tests, i_checker.failed_tests, i_checker.value_errors,
             i_checker.late_errors);
    if (i_checker.failed_tests == 0 && i_checker.late_errors == 0 &&
        i_checker.done_tests == NUM_TESTS) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (loaded);
    #((total_cycles + `FFT_FILL + MARGIN) * 4);
    $display("Run timed out after %0d cycles", total_cycles + `FFT_FILL + MARGIN);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* list.f */
+incdir+hw
hw/fft_data_pkg.sv
hw/fft_ctrl_pkg.sv
hw/sat_round.sv
hw/bf_stage1.sv
hw/delay_commutator.sv
hw/bf_stage2.sv
hw/fft_front_top.sv
bench/fft_checker.sv
bench/tb_fft_front.sv

/* Makefile */
# Verilator build and run of the FFT front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fft_front
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= FAIL: see errors above

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/fft_input.dat */
// Stimulus: hold cycles, lane0 up re im down re im, lane1 up re im down re im (10-bit)
// Expected, two records per line: lane0 up re im down re im, lane1 up re im down re im
028 005 3fd 005 3fd 020 000 020 000
028 1ff 200 1ff 200 1ff 1ff 1ff 1ff
0050 7fd0 0050 7fd0 03ff 0000 0000 7c01 0050 7fd0 0050 7fd0 03eb 7f38 7f38 7c15
0050 7fd0 0050 7fd0 03b1 7e79 7e79 7c4f 0050 7fd0 0050 7fd0 0353 7dc8 7dc8 7cad
0050 7fd0 0050 7fd0 02d3 7d2d 7d2d 7d2d 0050 7fd0 0050 7fd0 0238 7cad 7cad 7dc8
0050 7fd0 0050 7fd0 0187 7c4f 7c4f 7e79 0050 7fd0 0050 7fd0 00c8 7c15 7c15 7f38
0050 7fd0 7fd0 7fb0 0000 7c01 03ff 0000 0050 7fd0 7fd0 7fb0 7f38 7c15 03eb 7f38
0050 7fd0 7fd0 7fb0 7e79 7c4f 03b1 7e79 0050 7fd0 7fd0 7fb0 7dc8 7cad 0353 7dc8
0050 7fd0 7fd0 7fb0 7d2d 7d2d 02d3 7d2d 0050 7fd0 7fd0 7fb0 7cad 7dc8 0238 7cad
0050 7fd0 7fd0 7fb0 7c4f 7e79 0187 7c4f 0050 7fd0 7fd0 7fb0 7c15 7f38 00c8 7c15
1ff0 6000 1ff0 6000 3fd0 3fd0 3fd0 402f 1ff0 6000 1ff0 6000 3fff 3216 3216 4000
1ff0 6000 1ff0 6000 3fff 228e 228e 4000 1ff0 6000 1ff0 6000 3fff 11a7 11a7 4000
1ff0 6000 1ff0 6000 3fff 0000 0000 4000 1ff0 6000 1ff0 6000 3fff 6e58 6e58 4000
1ff0 6000 1ff0 6000 3fff 5d71 5d71 4000 1ff0 6000 1ff0 6000 3fff 4de9 4de9 4000
1ff0 6000 6000 6010 3fd0 402f 3fd0 3fd0 1ff0 6000 6000 6010 3216 4000 3fff 3216
1ff0 6000 6000 6010 228e 4000 3fff 228e 1ff0 6000 6000 6010 11a7 4000 3fff 11a7
1ff0 6000 6000 6010 0000 4000 3fff 0000 1ff0 6000 6000 6010 6e58 4000 3fff 6e58
1ff0 6000 6000 6010 5d71 4000 3fff 5d71 1ff0 6000 6000 6010 4de9 4000 3fff 4de9
